/* Bender.yml */
package:
  name: xbus_filter

sources:
  - design/xbus_filter_pkg.sv
  - design/xbus_filter_cache.sv
  - design/xbus_filter_cmd_gen.sv
  - design/xbus_filter_exec.sv
  - design/xbus_filter.sv
  - target: test
    files:
      - verification/xbus_filter_tb.sv

/* design/xbus_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module xbus_filter (
    input  logic                       clk,
    input  logic                       arst_n,
    input  xbus_filter_pkg::xbus_pkt_t in_pkt,
    input  xbus_filter_pkg::byte_t     pad_value,
    output logic                       vec_wr_en,
    output xbus_filter_pkg::vec_t      vec_din,
    input  logic                       vec_full,
    output logic                       cache_full
);
    import xbus_filter_pkg::*;

    xbus_pkt_t   cache_dout;
    step_t       cache_count;
    logic        cache_empty;
    logic        rd_en;
    step_t       rd_step;
    logic        gen_start;
    head_t       win;
    logic        cmd_valid;
    logic        cmd_ready;
    filter_cmd_t cmd;

    xbus_filter_cache xbus_filter_cache_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_pkt    (in_pkt),
        .rd_en     (rd_en),
        .rd_step   (rd_step),
        .dout      (cache_dout),
        .count     (cache_count),
        .empty     (cache_empty),
        .prog_full (cache_full)
    );

    xbus_filter_cmd_gen xbus_filter_cmd_gen_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .gen_start (gen_start),
        .win       (win),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd)
    );

    xbus_filter_exec xbus_filter_exec_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .pad_value   (pad_value),
        .cache_dout  (cache_dout),
        .cache_count (cache_count),
        .cache_empty (cache_empty),
        .rd_en       (rd_en),
        .rd_step     (rd_step),
        .gen_start   (gen_start),
        .win         (win),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd         (cmd),
        .vec_wr_en   (vec_wr_en),
        .vec_din     (vec_din),
        .vec_full    (vec_full)
    );

endmodule

`default_nettype wire

/* design/xbus_filter_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module xbus_filter_cache (
    input  logic                       clk,
    input  logic                       arst_n,
    input  xbus_filter_pkg::xbus_pkt_t in_pkt,
    input  logic                       rd_en,
    input  xbus_filter_pkg::step_t     rd_step,
    output xbus_filter_pkg::xbus_pkt_t dout,
    output xbus_filter_pkg::step_t     count,
    output logic                       empty,
    output logic                       prog_full
);
    import xbus_filter_pkg::*;

    typedef logic [CACHE_PTR_W-1:0] ptr_t;

    xbus_pkt_t mem [CACHE_DEPTH];
    xbus_pkt_t rd_pipe [CACHE_RD_LATENCY];
    xbus_pkt_t wr_data;
    logic      wr_en;
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    ptr_t      rd_ptr_next;
    step_t     count_next;

    // Only real packets are kept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_pkt.tag inside {HEAD, BODY, END};
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= in_pkt;
    end

    always_comb begin
        rd_ptr_next = rd_ptr;
        count_next = count;
        if (rd_en) begin
            rd_ptr_next = rd_ptr + ptr_t'(rd_step);
            count_next = count - rd_step;
        end
        if (wr_en) begin
            count_next = count_next + step_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            empty <= 1'b1;
            prog_full <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr_next;
            count <= count_next;
            empty <= count_next == '0;
            prog_full <= count_next > step_t'(CACHE_PROG_FULL);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Last entry of the step, then delay stages
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_pipe[0] <= mem[rd_ptr_next - 1'b1];
        end
        for (int i = 1; i < CACHE_RD_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign dout = rd_pipe[CACHE_RD_LATENCY-1];

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> count != step_t'(CACHE_DEPTH));

    a_step_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> rd_step <= count);

endmodule

`default_nettype wire

/* design/xbus_filter_cmd_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module xbus_filter_cmd_gen (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         gen_start,
    input  xbus_filter_pkg::head_t       win,
    output logic                         cmd_valid,
    input  logic                         cmd_ready,
    output xbus_filter_pkg::filter_cmd_t cmd
);
    import xbus_filter_pkg::*;

    gen_state_t  state;
    coord_t      kh_cnt;
    coord_t      kw_cnt;
    logic        adv;
    logic        walk;
    logic        last_pos;
    logic [1:5]  vld;
    logic [1:4]  first_p;
    logic [1:2]  end_p;
    coord_t      x1;
    coord_t      y1;
    logic        pad2;
    coord_t      xi2;
    coord_t      yi2;
    cmd_opcode_t op3;
    coord_t      row3;
    coord_t      xi3;
    coord_t      pix;
    cmd_opcode_t op4;
    step_t       word4;
    lane_t       lane4;
    logic        have_fetch;
    logic        seen;
    step_t       prev_word;
    cmd_opcode_t op5;
    step_t       step5;
    lane_t       lane5;

    // Whole pipeline moves only when the output slot is free
    assign adv = !cmd_valid || cmd_ready;
    assign walk = state inside {G_FIRST, G_CMD, G_END};
    assign last_pos = kh_cnt == coord_t'(KH - 1) && kw_cnt == coord_t'(KW - 1);
    assign pix = row3 + xi3;
    assign seen = have_fetch && !first_p[4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= G_IDLE;
            kh_cnt <= '0;
            kw_cnt <= '0;
        end else begin
            case (state)
                G_IDLE: if (gen_start) state <= G_FIRST;
                G_FIRST: if (adv) state <= G_CMD;
                G_CMD: if (adv && last_pos) state <= G_END;
                G_END: if (adv) state <= G_DONE;
                default: state <= G_IDLE;
            endcase
            if (adv && state inside {G_FIRST, G_CMD}) begin
                if (kw_cnt == coord_t'(KW - 1)) begin
                    kw_cnt <= '0;
                    kh_cnt <= last_pos ? '0 : kh_cnt + 1'b1;
                end else begin
                    kw_cnt <= kw_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld <= '0;
            cmd_valid <= 1'b0;
            have_fetch <= 1'b0;
        end else if (adv) begin
            vld <= {walk, vld[1:4]};
            cmd_valid <= vld[5];
            if (vld[4]) begin
                if (op4 == CMD_X) begin
                    have_fetch <= 1'b1;
                end else if (first_p[4] || op4 == CMD_E) begin
                    have_fetch <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            first_p <= {state == G_FIRST, first_p[1:3]};
            end_p <= {state == G_END, end_p[1]};
            x1 <= win.win_x + kw_cnt;
            y1 <= win.win_y + kh_cnt;
            // Padding border test
            pad2 <= (x1 < coord_t'(PAD_L)) || (x1 >= coord_t'(PAD_L + IMG_W))
                || (y1 < coord_t'(PAD_U)) || (y1 >= coord_t'(PAD_U + IMG_H));
            xi2 <= x1 - coord_t'(PAD_L);
            yi2 <= y1 - coord_t'(PAD_U);
            op3 <= end_p[2] ? CMD_E : (pad2 ? CMD_Z : CMD_X);
            row3 <= yi2 * coord_t'(IMG_W);
            xi3 <= xi2;
            op4 <= op3;
            word4 <= step_t'(pix >> LANE_W);
            lane4 <= lane_t'(pix);
            // Steps are relative to the previous fetch word
            op5 <= op4;
            lane5 <= (op4 == CMD_X) ? lane4 : '0;
            case (op4)
                CMD_X: step5 <= seen ? word4 - prev_word : word4 + 1'b1;
                CMD_E: step5 <= seen ? step_t'(WORDS_PER_IMAGE) - prev_word - 1'b1
                                     : step_t'(WORDS_PER_IMAGE);
                default: step5 <= '0;
            endcase
            if (vld[4] && op4 == CMD_X) begin
                prev_word <= word4;
            end
            cmd <= '{opcode: op5, step: step5, lane: lane5};
        end
    end

    // Fetch words never go back inside a window
    a_step_bound: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid |-> cmd.step <= step_t'(WORDS_PER_IMAGE));

endmodule

`default_nettype wire

/* design/xbus_filter_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module xbus_filter_exec (
    input  logic                         clk,
    input  logic                         arst_n,
    input  xbus_filter_pkg::byte_t       pad_value,
    input  xbus_filter_pkg::xbus_pkt_t   cache_dout,
    input  xbus_filter_pkg::step_t       cache_count,
    input  logic                         cache_empty,
    output logic                         rd_en,
    output xbus_filter_pkg::step_t       rd_step,
    output logic                         gen_start,
    output xbus_filter_pkg::head_t       win,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  xbus_filter_pkg::filter_cmd_t cmd,
    output logic                         vec_wr_en,
    output xbus_filter_pkg::vec_t        vec_din,
    input  logic                         vec_full
);
    import xbus_filter_pkg::*;

    // Vector write that travels alongside its cache read
    typedef struct packed {
        logic  valid;
        logic  fetch;
        lane_t lane;
    } wr_task_t;

    exec_state_t                 state;
    filter_cmd_t                 pend;
    logic                        pend_valid;
    filter_cmd_t                 act;
    logic                        act_valid;
    step_t                       in_flight;
    logic                        head_fits;
    logic                        cmd_fits;
    logic                        go;
    logic                        head_seen;
    logic                        end_seen;
    logic [CACHE_RD_LATENCY-1:0] rd_vld;
    wr_task_t                    new_task;
    wr_task_t                    wr_pipe [CACHE_RD_LATENCY+1];

    // New command first, else retry the pending one
    always_comb begin
        act_valid = 1'b0;
        act = pend;
        if (cmd_valid && cmd_ready) begin
            act_valid = 1'b1;
            act = cmd;
        end else if (pend_valid) begin
            act_valid = 1'b1;
        end
    end

    // Count must cover the read still in flight
    assign in_flight = rd_en ? rd_step : '0;
    assign head_fits = {1'b0, cache_count} >= {1'b0, in_flight} + 1'b1;
    assign cmd_fits = {1'b0, cache_count} >= {1'b0, in_flight} + {1'b0, act.step};

    always_comb begin
        case (act.opcode)
            CMD_Z: go = !vec_full;
            CMD_X: go = cmd_fits && !vec_full;
            default: go = cmd_fits;
        endcase
        go = go && act_valid && state == E_EXEC_CMD;
    end

    assign head_seen = state == E_WAIT_HEAD && rd_vld[CACHE_RD_LATENCY-1]
        && cache_dout.tag == HEAD;
    assign end_seen = state == E_WAIT_HEAD && rd_vld[CACHE_RD_LATENCY-1]
        && cache_dout.tag == END;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= E_IDLE;
        end else begin
            case (state)
                E_IDLE: if (!cache_empty) state <= E_RD_HEAD;
                E_RD_HEAD: if (head_fits) state <= E_WAIT_HEAD;
                E_WAIT_HEAD: begin
                    if (head_seen) begin
                        state <= E_EXEC_CMD;
                    end else if (end_seen) begin
                        state <= E_DONE;
                    end
                end
                E_EXEC_CMD: if (go && act.opcode == CMD_E) state <= E_RD_HEAD;
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_en <= 1'b0;
            cmd_ready <= 1'b0;
            pend_valid <= 1'b0;
            gen_start <= 1'b0;
            rd_vld <= '0;
        end else begin
            gen_start <= head_seen;
            rd_vld <= {rd_vld[CACHE_RD_LATENCY-2:0], rd_en};
            case (state)
                E_RD_HEAD: begin
                    rd_en <= head_fits;
                    cmd_ready <= 1'b0;
                    pend_valid <= 1'b0;
                end
                E_WAIT_HEAD: begin
                    rd_en <= 1'b0;
                    cmd_ready <= 1'b1;
                    pend_valid <= 1'b0;
                end
                E_EXEC_CMD: begin
                    // Zero step reuses the word already at the cache output
                    rd_en <= go && act.opcode != CMD_Z && act.step != '0;
                    if (act_valid) begin
                        cmd_ready <= go && act.opcode != CMD_E;
                        pend_valid <= !go;
                    end
                end
                default: begin
                    rd_en <= 1'b0;
                    cmd_ready <= 1'b0;
                    pend_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (head_seen) begin
            win <= head_t'(cache_dout.data);
        end
        if (cmd_valid && cmd_ready) begin
            pend <= cmd;
        end
        if (state == E_RD_HEAD) begin
            rd_step <= step_t'(1);
        end else if (state == E_EXEC_CMD && act_valid) begin
            rd_step <= act.step;
        end
    end

    assign new_task = '{valid: go && act.opcode != CMD_E,
                        fetch: act.opcode == CMD_X,
                        lane: act.lane};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_pipe <= '{default: '0};
        end else begin
            wr_pipe[0] <= new_task;
            for (int i = 1; i <= CACHE_RD_LATENCY; i++) begin
                wr_pipe[i] <= wr_pipe[i-1];
            end
        end
    end

    assign vec_wr_en = wr_pipe[CACHE_RD_LATENCY].valid;

    // One byte per channel group, or the pad byte
    always_comb begin
        for (int j = 0; j < S; j++) begin
            if (wr_pipe[CACHE_RD_LATENCY].fetch) begin
                vec_din[j*8 +: 8] =
                    cache_dout.data[(j * Q + wr_pipe[CACHE_RD_LATENCY].lane) * 8 +: 8];
            end else begin
                vec_din[j*8 +: 8] = pad_value;
            end
        end
    end

    a_no_write_idle: assert property (@(posedge clk) disable iff (!arst_n)
        state == E_IDLE |-> !vec_wr_en);

endmodule

`default_nettype wire

/* design/xbus_filter_pkg.sv */
`default_nettype none

package xbus_filter_pkg;

    // Image and kernel geometry
    localparam int Q = 4;
    localparam int S = 2;
    localparam int DATA_W = Q * S * 8;
    localparam int IMG_H = 6;
    localparam int IMG_W = 6;
    localparam int KH = 3;
    localparam int KW = 3;
    localparam int PAD_U = 1;
    localparam int PAD_L = 1;
    localparam int WORDS_PER_IMAGE = IMG_H * IMG_W / Q;

    // Cache FIFO
    localparam int CACHE_DEPTH = 32;
    localparam int CACHE_PROG_FULL = 24;
    localparam int CACHE_RD_LATENCY = 3;
    localparam int CACHE_PTR_W = $clog2(CACHE_DEPTH);
    localparam int STEP_W = $clog2(CACHE_DEPTH + 1);
    localparam int LANE_W = $clog2(Q);

    typedef logic [15:0] coord_t;
    typedef logic [STEP_W-1:0] step_t;
    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [7:0] byte_t;
    typedef logic [S*8-1:0] vec_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        HEAD = 2'd1,
        BODY = 2'd2,
        END  = 2'd3
    } xbus_tag_t;

    typedef struct packed {
        xbus_tag_t         tag;
        logic [DATA_W-1:0] data;
    } xbus_pkt_t;

    // Window corner as carried in a HEAD word
    typedef struct packed {
        logic [DATA_W-33:0] rsvd;
        coord_t             win_y;
        coord_t             win_x;
    } head_t;

    typedef enum logic [1:0] {
        CMD_Z,
        CMD_X,
        CMD_E
    } cmd_opcode_t;

    typedef struct packed {
        cmd_opcode_t opcode;
        step_t       step;
        lane_t       lane;
    } filter_cmd_t;

    typedef enum logic [2:0] {
        E_IDLE,
        E_RD_HEAD,
        E_WAIT_HEAD,
        E_EXEC_CMD,
        E_DONE
    } exec_state_t;

    typedef enum logic [2:0] {
        G_IDLE,
        G_FIRST,
        G_CMD,
        G_END,
        G_DONE
    } gen_state_t;

endpackage

`default_nettype wire

/* files.f */
design/xbus_filter_pkg.sv
design/xbus_filter_cache.sv
design/xbus_filter_cmd_gen.sv
design/xbus_filter_exec.sv
design/xbus_filter.sv
verification/xbus_filter_tb.sv

/* verification/xbus_filter_patterns.txt */
// Header in hex: pad byte, packet count, vector count
// Packets: top digit is the tag, then the 64-bit word; vectors: group 1 byte, group 0 byte
5a 29 24

// Window at (0,0)
10000000000000000
28382818003020100 28786858407060504 28b8a89880b0a0908
28f8e8d8c0f0e0d0c 29392919013121110 29796959417161514
29b9a99981b1a1918 29f9e9d9c1f1e1d1c 2a3a2a1a023222120
// Window at x=2, y=3
10000000000030002
28382818003020100 28786858407060504 28b8a89880b0a0908
28f8e8d8c0f0e0d0c 29392919013121110 29796959417161514
29b9a99981b1a1918 29f9e9d9c1f1e1d1c 2a3a2a1a023222120
// Window at x=5, y=5
10000000000050005
28382818003020100 28786858407060504 28b8a89880b0a0908
28f8e8d8c0f0e0d0c 29392919013121110 29796959417161514
29b9a99981b1a1918 29f9e9d9c1f1e1d1c 2a3a2a1a023222120
// Window at x=7, y=0, all padding
10000000000000007
28382818003020100 28786858407060504 28b8a89880b0a0908
28f8e8d8c0f0e0d0c 29392919013121110 29796959417161514
29b9a99981b1a1918 29f9e9d9c1f1e1d1c 2a3a2a1a023222120
30000000000000000

// Expected vectors, one window per line
5a5a 5a5a 5a5a 5a5a 8000 8101 5a5a 8606 8707
8d0d 8e0e 8f0f 9313 9414 9515 9919 9a1a 9b1b
9c1c 9d1d 5a5a a222 a323 5a5a 5a5a 5a5a 5a5a
5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a 5a5a

/* verification/xbus_filter_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module xbus_filter_tb;
    import xbus_filter_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CHECK_CYCLES = 5;
    localparam int DRAIN_CYCLES = 40;
    localparam int CYCLES_PER_VEC = 60;
    localparam int TIMEOUT_MARGIN = 300;
    localparam int HDR_WORDS = 3;
    localparam int PAT_WORDS = 80;
    localparam int PKT_W = $bits(xbus_pkt_t);
    localparam int PAT_W = 4 * ((PKT_W + 3) / 4);
    localparam int unsigned SEED = 32'hc5a7d3a9;

    logic      clk;
    logic      arst_n;
    xbus_pkt_t in_pkt;
    byte_t     pad_value;
    logic      vec_wr_en;
    vec_t      vec_din;
    logic      vec_full;
    logic      cache_full;

    logic [PAT_W-1:0] pat [PAT_WORDS];
    int               n_pkt;
    int               n_vec;
    int               pkt_idx;
    int               vec_idx;
    int               cycle_cnt;
    int               cycle_limit;
    int unsigned      seed_var;

    xbus_filter xbus_filter_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_pkt     (in_pkt),
        .pad_value  (pad_value),
        .vec_wr_en  (vec_wr_en),
        .vec_din    (vec_din),
        .vec_full   (vec_full),
        .cache_full (cache_full)
    );

    always #(HALF_PERIOD) clk = ~clk;

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic load_patterns();
        $readmemh("verification/xbus_filter_patterns.txt", pat);
        pad_value = pat[0][7:0];
        n_pkt = pat[1][31:0];
        n_vec = pat[2][31:0];
        assert (HDR_WORDS + n_pkt + n_vec == PAT_WORDS) else begin
            $display("Pattern file lists %0d packets and %0d vectors, expected %0d entries",
                     n_pkt, n_vec, PAT_WORDS);
            stop_on_error();
        end
        cycle_limit = CYCLES_PER_VEC * n_vec + TIMEOUT_MARGIN;
    endtask

    function automatic vec_t expected_vec(input int idx);
        return pat[HDR_WORDS + n_pkt + idx][$bits(vec_t)-1:0];
    endfunction

    // Source holds off while the cache reports full
    task automatic drive_cycle(input logic send, input logic full);
        @(posedge clk);
        #DRIVE_DELAY;
        vec_full = full;
        if (send && pkt_idx < n_pkt && !cache_full) begin
            in_pkt = xbus_pkt_t'(pat[HDR_WORDS + pkt_idx][PKT_W-1:0]);
            pkt_idx++;
        end else begin
            in_pkt.tag = IDLE;
            in_pkt.data = '0;
        end
    endtask

    task automatic check_quiet(input string test_name);
        assert (!vec_wr_en && !cache_full) else begin
            $display("ERROR %s: expected 0 and 0, actual vec_wr_en=%b cache_full=%b",
                     test_name, vec_wr_en, cache_full);
            stop_on_error();
        end
    endtask

    // Written vectors are compared in order
    always @(negedge clk) begin
        if (arst_n && vec_wr_en) begin
            assert (vec_idx < n_vec) else begin
                $display("Vector %h was written after the last expected vector", vec_din);
                stop_on_error();
            end
            assert (vec_din == expected_vec(vec_idx)) else begin
                $display("ERROR vectors window %0d pos %0d: expected %h, actual %h",
                         vec_idx / (KH * KW), vec_idx % (KH * KW), expected_vec(vec_idx), vec_din);
                stop_on_error();
            end
            vec_idx++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Run timed out after %0d cycles with %0d of %0d vectors written",
                     cycle_cnt, vec_idx, n_vec);
            stop_on_error();
        end
    end

    initial begin
        logic send;
        logic full;

        clk = 1'b0;
        arst_n = 1'b0;
        in_pkt.tag = IDLE;
        in_pkt.data = '0;
        pad_value = '0;
        vec_full = 1'b0;
        pkt_idx = 0;
        vec_idx = 0;
        cycle_cnt = 0;
        cycle_limit = 0;
        seed_var = SEED;
        void'($urandom(seed_var));
        load_patterns();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        repeat (IDLE_CHECK_CYCLES) begin
            drive_cycle(1'b0, 1'b0);
            check_quiet("reset_idle");
        end

        // Consumer blocked so the cache fills up
        while (!cache_full && pkt_idx < n_pkt) begin
            drive_cycle(1'b1, 1'b1);
        end
        assert (cache_full) else begin
            $display("ERROR fill_cache_full: expected cache_full=1, actual cache_full=%b",
                     cache_full);
            stop_on_error();
        end

        while (pkt_idx < n_pkt || vec_idx < n_vec) begin
            send = ($urandom % 4) != 0;
            full = ($urandom % 4) == 0;
            drive_cycle(send, full);
        end

        repeat (DRAIN_CYCLES) drive_cycle(1'b0, 1'b0);
        assert (!cache_full) else begin
            $display("ERROR drain_cache_full: expected cache_full=0, actual cache_full=%b",
                     cache_full);
            stop_on_error();
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
